//--- include/denise_defs.svh
////////////////////////////////////////
// Denise playfield path constants
// Bus widths, register map and chip ID
////////////////////////////////////////

`ifndef DENISE_DEFS_SVH
`define DENISE_DEFS_SVH

// RGA carries word address bits 8:1
`define DEN_RGA_W             8
// Data bus and bitplane word
`define DEN_WORD_W            16

// Playfield resources
`define DEN_NUM_PLANES        6
`define DEN_CLUT_DEPTH        32
`define DEN_CLUT_IDX_W        5
`define DEN_PIX_IDX_W         6

// Register word addresses are byte addresses shifted right by one
`define DEN_ADDR_BPLCON0      8'h80
`define DEN_ADDR_BPLCON2      8'h82
`define DEN_ADDR_BPLDAT_BASE  8'h88
`define DEN_ADDR_COLOR_BASE   8'hC0
`define DEN_ADDR_DENISEID     8'h3E
`define DEN_ADDR_IDLE         8'hFF

// ECS Denise identifies itself with this value
`define DEN_ID_VALUE          16'hFFFC

`endif

//--- src/denise_pkg.sv
////////////////////////////////////////
// Denise shared types
// Register select, bus write, control and colour
////////////////////////////////////////

`include "denise_defs.svh"

package denise_pkg;

  ////////////////////////////////////////
  // Register select
  ////////////////////////////////////////

  // Which register a decoded access hits
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_BPLCON0,
    SEL_BPLCON2,
    SEL_BPLDAT,
    SEL_COLOR,
    SEL_DENISEID
  } reg_sel_e;

  ////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////

  // Write on its data cycle
  typedef struct packed {
    reg_sel_e                   sel;
    // Plane number or colour number
    logic [`DEN_CLUT_IDX_W-1:0] idx;
    logic [`DEN_WORD_W-1:0]     data;
  } bus_wr_t;

  // Playfield fields of BPLCON0 and BPLCON2
  typedef struct packed {
    logic [2:0] bpu;
    logic       dblpf;
    logic       pf2pri;
    logic [2:0] pf2p;
  } bpl_ctrl_t;

  // 12-bit OCS colour
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

endpackage

//--- src/reg_decode.sv
////////////////////////////////////////
// Register decode
// Samples RGA, holds playfield control fields
// and answers the DENISEID read
////////////////////////////////////////

`include "denise_defs.svh"

module reg_decode (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [`DEN_RGA_W-1:0]      rga,
  input  logic [`DEN_WORD_W-1:0]     db_in,
  input  logic                       cfg_ecs,
  output denise_pkg::bus_wr_t        wr,
  output denise_pkg::bpl_ctrl_t      ctrl,
  output logic [`DEN_WORD_W-1:0]     db_out,
  output logic                       db_oen
);

  denise_pkg::reg_sel_e        sel_d;
  denise_pkg::reg_sel_e        sel_q;
  logic [`DEN_CLUT_IDX_W-1:0]  idx_d;
  logic [`DEN_CLUT_IDX_W-1:0]  idx_q;
  logic                        id_rd;

  ////////////////////////////////////////
  // Address cycle
  ////////////////////////////////////////

  always_comb begin
    sel_d = denise_pkg::SEL_NONE;
    // Idle slot on the bus
    if (rga == `DEN_ADDR_IDLE) begin
      sel_d = denise_pkg::SEL_NONE;
    end else if (rga == `DEN_ADDR_BPLCON0) begin
      sel_d = denise_pkg::SEL_BPLCON0;
    end else if (rga == `DEN_ADDR_BPLCON2) begin
      sel_d = denise_pkg::SEL_BPLCON2;
    end else if ({rga[`DEN_RGA_W-1:3], 3'b000} == `DEN_ADDR_BPLDAT_BASE) begin
      // BPL1DAT to BPL8DAT
      sel_d = denise_pkg::SEL_BPLDAT;
    end else if ({rga[`DEN_RGA_W-1:5], 5'b00000} == `DEN_ADDR_COLOR_BASE) begin
      // COLOR00 to COLOR31
      sel_d = denise_pkg::SEL_COLOR;
    end else if (rga == `DEN_ADDR_DENISEID) begin
      sel_d = denise_pkg::SEL_DENISEID;
    end
    // Plane number from bits 3:1, colour number from bits 5:1
    idx_d = (sel_d == denise_pkg::SEL_BPLDAT) ? {2'b00, rga[2:0]} : rga[4:0];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel_q <= denise_pkg::SEL_NONE;
      idx_q <= '0;
    end else begin
      sel_q <= sel_d;
      idx_q <= idx_d;
    end
  end

  // Consumers write on the edge after the data cycle
  assign wr = '{sel: sel_q, idx: idx_q, data: db_in};

  ////////////////////////////////////////
  // BPLCON0 / BPLCON2
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl <= '0;
    end else begin
      if (wr.sel == denise_pkg::SEL_BPLCON0) begin
        ctrl.bpu   <= wr.data[14:12];
        ctrl.dblpf <= wr.data[10];
      end
      if (wr.sel == denise_pkg::SEL_BPLCON2) begin
        ctrl.pf2pri <= wr.data[6];
        ctrl.pf2p   <= wr.data[5:3];
      end
    end
  end

  ////////////////////////////////////////
  // DENISEID read
  ////////////////////////////////////////

  // OCS parts leave the bus floating
  assign id_rd = (sel_q == denise_pkg::SEL_DENISEID) && cfg_ecs;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      db_oen <= 1'b0;
      db_out <= '0;
    end else begin
      db_oen <= id_rd;
      db_out <= id_rd ? `DEN_ID_VALUE : '0;
    end
  end

  // Bus only driven two edges after a DENISEID address
  a_oen_after_id : assert property (@(posedge clk) disable iff (!arst_n)
    db_oen |-> ($past(rga, 2) == `DEN_ADDR_DENISEID));

endmodule

//--- src/bitplane_shifter.sv
////////////////////////////////////////
// Bitplane shifters
// BPLxDAT holding registers, plane enables
// and the six lores pixel shifters
////////////////////////////////////////

`include "denise_defs.svh"

module bitplane_shifter (
  input  logic                        clk,
  input  logic                        arst_n,
  input  denise_pkg::bus_wr_t         wr,
  input  denise_pkg::bpl_ctrl_t       ctrl,
  output logic [`DEN_NUM_PLANES-1:0]  planes
);

  logic [`DEN_WORD_W-1:0]     bpldat_q [`DEN_NUM_PLANES];
  logic [`DEN_WORD_W-1:0]     shift_q  [`DEN_NUM_PLANES];
  logic [`DEN_NUM_PLANES:0]   run;
  logic [`DEN_NUM_PLANES-1:0] mask_d;
  logic [`DEN_NUM_PLANES-1:0] mask_q;
  logic                       bpl1_wr;
  logic                       load_q;

  ////////////////////////////////////////
  // Plane enables
  ////////////////////////////////////////

  // BPL1DAT is written last and starts the word
  assign bpl1_wr = (wr.sel == denise_pkg::SEL_BPLDAT) && (wr.idx == '0);

  always_comb begin
    // bpu ones from plane 1 up
    run = ({{`DEN_NUM_PLANES{1'b0}}, 1'b1} << ctrl.bpu) - 1'b1;
    // BPU 6 and 7 both enable all six planes
    if (ctrl.bpu >= 3'd6) begin
      mask_d = '1;
    end else begin
      mask_d = run[`DEN_NUM_PLANES-1:0];
    end
  end

  ////////////////////////////////////////
  // Holding registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `DEN_NUM_PLANES; i++) begin
        bpldat_q[i] <= '0;
      end
      mask_q <= '0;
      load_q <= 1'b0;
    end else begin
      // BPL7DAT and BPL8DAT go nowhere
      if ((wr.sel == denise_pkg::SEL_BPLDAT) && (wr.idx < `DEN_NUM_PLANES)) begin
        bpldat_q[wr.idx[2:0]] <= wr.data;
      end
      if (bpl1_wr) begin
        mask_q <= mask_d;
      end
      load_q <= bpl1_wr;
    end
  end

  ////////////////////////////////////////
  // Shifters
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `DEN_NUM_PLANES; i++) begin
        shift_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `DEN_NUM_PLANES; i++) begin
        if (load_q) begin
          // Disabled planes load as zero
          shift_q[i] <= bpldat_q[i] & {`DEN_WORD_W{mask_q[i]}};
        end else begin
          shift_q[i] <= {shift_q[i][`DEN_WORD_W-2:0], 1'b0};
        end
      end
    end
  end

  // MSB of each shifter is the current pixel
  always_comb begin
    for (int i = 0; i < `DEN_NUM_PLANES; i++) begin
      planes[i] = shift_q[i][`DEN_WORD_W-1];
    end
  end

  // Plane mask at load time is a run of ones from plane 1
  a_mask_run : assert property (@(posedge clk) disable iff (!arst_n)
    load_q |-> ((({1'b0, mask_q} + 1'b1) & {1'b0, mask_q}) == '0));

endmodule

//--- src/playfield_priority.sv
////////////////////////////////////////
// Playfield priority
// Plane bits to colour index in single or dual playfield mode
////////////////////////////////////////

`include "denise_defs.svh"

module playfield_priority (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [`DEN_NUM_PLANES-1:0]  planes,
  input  denise_pkg::bpl_ctrl_t       ctrl,
  output logic [`DEN_PIX_IDX_W-1:0]   pix_idx
);

  logic [2:0]                 pf1;
  logic [2:0]                 pf2;
  logic                       pf1_vld;
  logic                       pf2_vld;
  logic [`DEN_PIX_IDX_W-1:0]  idx_d;

  ////////////////////////////////////////
  // Playfield split
  ////////////////////////////////////////

  // Odd planes form PF1, even planes PF2
  assign pf1     = {planes[4], planes[2], planes[0]};
  assign pf2     = {planes[5], planes[3], planes[1]};
  assign pf1_vld = |pf1;
  assign pf2_vld = |pf2;

  ////////////////////////////////////////
  // Index select
  ////////////////////////////////////////

  always_comb begin
    if (!ctrl.dblpf) begin
      // Undocumented OCS/ECS quirk where plane 5 forces COLOR16
      if ((ctrl.pf2p >= 3'd5) && planes[4]) begin
        idx_d = 6'd16;
      end else begin
        idx_d = planes;
      end
    end else if (ctrl.pf2pri) begin
      // PF2 in front
      if (pf2_vld) begin
        idx_d = {3'b001, pf2};
      end else if (pf1_vld) begin
        idx_d = {3'b000, pf1};
      end else begin
        idx_d = '0;
      end
    end else begin
      // PF1 in front
      if (pf1_vld) begin
        idx_d = {3'b000, pf1};
      end else if (pf2_vld) begin
        // PF2 uses colours 8 to 15
        idx_d = {3'b001, pf2};
      end else begin
        idx_d = '0;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pix_idx <= '0;
    end else begin
      pix_idx <= idx_d;
    end
  end

endmodule

//--- src/color_lookup.sv
////////////////////////////////////////
// Colour look-up
// 32-entry CLUT with extra-half-brite output
////////////////////////////////////////

`include "denise_defs.svh"

module color_lookup (
  input  logic                       clk,
  input  logic                       arst_n,
  input  denise_pkg::bus_wr_t        wr,
  input  logic                       cfg_a1k,
  input  logic [`DEN_PIX_IDX_W-1:0]  pix_idx,
  output denise_pkg::rgb_t           rgb
);

  denise_pkg::rgb_t          clut_q [`DEN_CLUT_DEPTH];
  logic [`DEN_CLUT_DEPTH-1:0] valid_q;
  logic [`DEN_CLUT_IDX_W-1:0] rd_idx;
  denise_pkg::rgb_t          rd_q;
  logic                      ehb_q;

  ////////////////////////////////////////
  // CLUT write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wr.sel == denise_pkg::SEL_COLOR) begin
      clut_q[wr.idx] <= wr.data[11:0];
    end
  end

  // Entries never written read as black
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (wr.sel == denise_pkg::SEL_COLOR) begin
      valid_q[wr.idx] <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Read and EHB
  ////////////////////////////////////////

  assign rd_idx = pix_idx[`DEN_CLUT_IDX_W-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_q  <= '0;
      ehb_q <= 1'b0;
      rgb   <= '0;
    end else begin
      rd_q  <= valid_q[rd_idx] ? clut_q[rd_idx] : '0;
      // Sixth plane travels alongside the read
      ehb_q <= pix_idx[`DEN_PIX_IDX_W-1];
      // A1000 Denise has no half-brite
      if (ehb_q && !cfg_a1k) begin
        rgb <= '{red:   {1'b0, rd_q.red[3:1]},
                 green: {1'b0, rd_q.green[3:1]},
                 blue:  {1'b0, rd_q.blue[3:1]}};
      end else begin
        rgb <= rd_q;
      end
    end
  end

  a_color_idx : assert property (@(posedge clk) disable iff (!arst_n)
    (wr.sel == denise_pkg::SEL_COLOR) |-> (wr.idx < `DEN_CLUT_DEPTH));

endmodule

//--- src/denise_video.sv
////////////////////////////////////////
// Denise playfield video path
// Register decode, shifters, priority, CLUT
////////////////////////////////////////

`include "denise_defs.svh"

module denise_video (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    cfg_ecs,
  input  logic                    cfg_a1k,
  input  logic [`DEN_RGA_W-1:0]   rga,
  input  logic [`DEN_WORD_W-1:0]  db_in,
  output logic [`DEN_WORD_W-1:0]  db_out,
  output logic                    db_oen,
  output denise_pkg::rgb_t        rgb
);

  denise_pkg::bus_wr_t         wr;
  denise_pkg::bpl_ctrl_t       ctrl;
  logic [`DEN_NUM_PLANES-1:0]  planes;
  logic [`DEN_PIX_IDX_W-1:0]   pix_idx;

  reg_decode u_reg_decode (
    .clk     (clk),
    .arst_n  (arst_n),
    .rga     (rga),
    .db_in   (db_in),
    .cfg_ecs (cfg_ecs),
    .wr      (wr),
    .ctrl    (ctrl),
    .db_out  (db_out),
    .db_oen  (db_oen)
  );

  bitplane_shifter u_bitplane_shifter (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (wr),
    .ctrl   (ctrl),
    .planes (planes)
  );

  playfield_priority u_playfield_priority (
    .clk     (clk),
    .arst_n  (arst_n),
    .planes  (planes),
    .ctrl    (ctrl),
    .pix_idx (pix_idx)
  );

  color_lookup u_color_lookup (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr      (wr),
    .cfg_a1k (cfg_a1k),
    .pix_idx (pix_idx),
    .rgb     (rgb)
  );

endmodule

//--- dv/tb_denise.sv
////////////////////////////////////////
// Denise playfield path testbench
// Random bitplane words against a reference model
////////////////////////////////////////

`include "denise_defs.svh"

module tb_denise;
  timeunit 1ns;
  timeprecision 100ps;

  // Cycle budget for reset, colours, control writes, words, back-to-back and reads
  localparam int WORD_CYCLES = 40;
  localparam int TEST_CYCLES = 3 + 32 * 2 + 7 * 4 + 20 * WORD_CYCLES + 60;
  localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2 + 200;

  logic                    clk;
  logic                    arst_n;
  logic                    cfg_ecs;
  logic                    cfg_a1k;
  logic [`DEN_RGA_W-1:0]   rga;
  logic [`DEN_WORD_W-1:0]  db_in;
  logic [`DEN_WORD_W-1:0]  db_out;
  logic                    db_oen;
  denise_pkg::rgb_t        rgb;

  // Model of the register state
  denise_pkg::rgb_t [31:0] model_clut;
  logic [5:0][15:0]        model_bpl;
  denise_pkg::bpl_ctrl_t   model_ctrl;
  logic [16:0]             lfsr_state;
  int                      cyc = 0;
  // Expected rgb keyed by edge count
  denise_pkg::rgb_t        exp_rgb [int];
  string                   exp_name [int];

  denise_video DUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .cfg_ecs (cfg_ecs),
    .cfg_a1k (cfg_a1k),
    .rga     (rga),
    .db_in   (db_in),
    .db_out  (db_out),
    .db_oen  (db_oen),
    .rgb     (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Plane p enabled when p is below bpu
  function automatic logic [5:0] plane_mask(input logic [2:0] bpu);
    logic [5:0] m;
    for (int p = 0; p < 6; p++) begin
      m[p] = (p < int'(bpu));
    end
    return m;
  endfunction

  function automatic denise_pkg::rgb_t ref_pixel(input denise_pkg::rgb_t [31:0] clut,
      input logic [5:0][15:0] words, input logic [5:0] mask,
      input denise_pkg::bpl_ctrl_t ctrl, input logic a1k, input int k);
    logic [5:0]       bits;
    logic [2:0]       pf1;
    logic [2:0]       pf2;
    logic [5:0]       idx;
    denise_pkg::rgb_t ent;
    bits = '0;
    // Shifters empty after 16 pixels
    if (k < 16) begin
      for (int p = 0; p < 6; p++) begin
        bits[p] = words[p][15 - k] & mask[p];
      end
    end
    pf1 = {bits[4], bits[2], bits[0]};
    pf2 = {bits[5], bits[3], bits[1]};
    if (!ctrl.dblpf) begin
      idx = ((ctrl.pf2p >= 3'd5) && bits[4]) ? 6'd16 : bits;
    end else if (ctrl.pf2pri && (pf2 != 3'd0)) begin
      idx = 6'd8 + {3'b000, pf2};
    end else if (pf1 != 3'd0) begin
      idx = {3'b000, pf1};
    end else if (pf2 != 3'd0) begin
      idx = 6'd8 + {3'b000, pf2};
    end else begin
      idx = '0;
    end
    ent = clut[idx[4:0]];
    // Half-brite on 32 to 63 unless A1000
    if (idx[5] && !a1k) begin
      ent.red   = ent.red >> 1;
      ent.green = ent.green >> 1;
      ent.blue  = ent.blue >> 1;
    end
    return ent;
  endfunction

  ////////////////////////////////////////
  // Compare and failure
  ////////////////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_rgb(input string name, input denise_pkg::rgb_t exp,
      input denise_pkg::rgb_t act);
    if (act !== exp) begin
      fail_stop($sformatf("Error %s: expected %03h, actual %03h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      fail_stop($sformatf("Error %s: expected %04h, actual %04h", name, exp, act));
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYCLE_LIMIT) begin
      fail_stop($sformatf("Timeout after %0d cycles, tests did not finish", cyc));
    end
  end

  // rgb sampled mid-cycle
  always @(negedge clk) begin
    if (exp_rgb.exists(cyc)) begin
      check_rgb(exp_name[cyc], exp_rgb[cyc], rgb);
      exp_rgb.delete(cyc);
      exp_name.delete(cyc);
    end
  end

  ////////////////////////////////////////
  // Bus tasks called on a falling edge
  ////////////////////////////////////////

  task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
    rga = addr;
    @(negedge clk);
    // Data cycle
    rga = `DEN_ADDR_IDLE;
    db_in = data;
    @(negedge clk);
  endtask

  task automatic set_color(input logic [4:0] idx, input denise_pkg::rgb_t col);
    write_reg(`DEN_ADDR_COLOR_BASE | {3'b000, idx}, {4'h0, col});
    model_clut[idx] = col;
  endtask

  task automatic set_ctrl(input logic [2:0] bpu, input logic dblpf, input logic pf2pri,
      input logic [2:0] pf2p);
    write_reg(`DEN_ADDR_BPLCON0, {1'b0, bpu, 1'b0, dblpf, 10'h000});
    write_reg(`DEN_ADDR_BPLCON2, {9'h000, pf2pri, pf2p, 3'b000});
    model_ctrl = '{bpu: bpu, dblpf: dblpf, pf2pri: pf2pri, pf2p: pf2p};
  endtask

  task automatic write_plane(input logic [2:0] plane, input logic [15:0] data);
    write_reg(`DEN_ADDR_BPLDAT_BASE | {5'b00000, plane}, data);
    model_bpl[plane] = data;
  endtask

  task automatic load_first_plane(input logic [15:0] data, output int a_edge);
    // Address goes out on the coming rising edge
    a_edge = cyc + 1;
    write_plane(3'd0, data);
  endtask

  task automatic expect_word(input string name, input int a_edge);
    logic [5:0] mask;
    int         key;
    mask = plane_mask(model_ctrl.bpu);
    for (int k = 0; k < 18; k++) begin
      key = a_edge + 5 + k;
      exp_rgb[key]  = ref_pixel(model_clut, model_bpl, mask, model_ctrl, cfg_a1k, k);
      exp_name[key] = $sformatf("%s pixel %0d", name, k);
    end
  endtask

  task automatic wait_pixels_done();
    while (exp_rgb.num() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic show_word(input string name);
    logic [15:0] w;
    int          a;
    // BPL6DAT down to BPL2DAT first and BPL1DAT last to start the word
    for (int p = 5; p >= 1; p--) begin
      w = rand_bits(16);
      write_plane(3'(p), w);
    end
    w = rand_bits(16);
    load_first_plane(w, a);
    expect_word(name, a);
    wait_pixels_done();
  endtask

  task automatic read_id(input string name);
    rga = `DEN_ADDR_DENISEID;
    @(negedge clk);
    rga = `DEN_ADDR_IDLE;
    check_word({name, " early"}, 16'h0000, {15'h0000, db_oen});
    @(negedge clk);
    check_word({name, " oen"}, {15'h0000, cfg_ecs}, {15'h0000, db_oen});
    if (cfg_ecs) begin
      check_word({name, " data"}, `DEN_ID_VALUE, db_out);
    end
    @(negedge clk);
    check_word({name, " release"}, 16'h0000, {15'h0000, db_oen});
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [15:0] r;
    int          a_first;
    int          a_second;
    rga     = `DEN_ADDR_IDLE;
    db_in   = '0;
    cfg_ecs = 1'b1;
    cfg_a1k = 1'b0;
    arst_n  = 1'b0;
    model_clut = '0;
    model_bpl  = '0;
    model_ctrl = '0;
    lfsr_state = 17'd85548;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    check_rgb("reset rgb", '0, rgb);
    check_word("reset oen", 16'h0000, {15'h0000, db_oen});
    // Unwritten CLUT shows black
    set_ctrl(3'd6, 1'b0, 1'b0, 3'd0);
    show_word("reset_clut");

    // Single playfield with four planes
    for (int i = 0; i < 32; i++) begin
      r = rand_bits(12);
      set_color(5'(i), r[11:0]);
    end
    r = rand_bits(3);
    set_ctrl(3'd4, 1'b0, 1'b0, r[2:0]);
    repeat (4) show_word("spf_bpu4");

    // Half-brite, then A1000, then the PF2P quirk
    set_ctrl(3'd6, 1'b0, 1'b0, 3'd0);
    repeat (3) show_word("ehb");
    cfg_a1k = 1'b1;
    repeat (3) show_word("ehb_a1k");
    cfg_a1k = 1'b0;
    set_ctrl(3'd6, 1'b0, 1'b0, 3'd5);
    repeat (3) show_word("pf2p5");

    // Dual playfield with both priorities
    r = rand_bits(3);
    set_ctrl(3'd6, 1'b1, 1'b0, r[2:0]);
    repeat (3) show_word("dpf_pf1_front");
    r = rand_bits(3);
    set_ctrl(3'd6, 1'b1, 1'b1, r[2:0]);
    repeat (3) show_word("dpf_pf2_front");

    // Second BPL1DAT 8 edges after the first
    set_ctrl(3'd4, 1'b0, 1'b0, 3'd0);
    for (int p = 5; p >= 1; p--) begin
      r = rand_bits(16);
      write_plane(3'(p), r);
    end
    r = rand_bits(16);
    load_first_plane(r, a_first);
    expect_word("b2b_first", a_first);
    r = rand_bits(16);
    write_plane(3'd1, r);
    r = rand_bits(16);
    write_plane(3'd2, r);
    while (cyc != a_first + 7) begin
      @(negedge clk);
    end
    r = rand_bits(16);
    load_first_plane(r, a_second);
    expect_word("b2b_second", a_second);
    wait_pixels_done();

    // DENISEID on ECS and OCS
    cfg_ecs = 1'b1;
    read_id("id_ecs");
    cfg_ecs = 1'b0;
    read_id("id_ocs");

    $display("sim passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
src/denise_pkg.sv
src/reg_decode.sv
src/bitplane_shifter.sv
src/playfield_priority.sv
src/color_lookup.sv
src/denise_video.sv
dv/tb_denise.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_denise
FILELIST  ?= verilog.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wno-fatal --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
